// File: src/spmm_fmt_pkg.sv
package spmm_fmt_pkg;

  // ==================================================
  // Matrix dimensions and widths
  // ==================================================
  localparam int DATA_WIDTH      = 8;
  localparam int WH_DATA_WIDTH   = 12;
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  // One extra code so a full row of 16 fits
  localparam int ROW_LEN_WIDTH   = $clog2(NUM_FEATURE_IN + 1);
  localparam int NUM_NODE_WIDTH  = 4;
  localparam int NNZ_ADDR_WIDTH  = 8;

  // ==================================================
  // Scalar types
  // ==================================================
  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_data_t;
  typedef logic [COL_IDX_WIDTH-1:0]        col_idx_t;

  // Index 0 is the top slice, so feature 0 lands in the MSBs
  typedef logic [0:NUM_FEATURE_OUT-1][WH_DATA_WIDTH-1:0] wh_sums_t;

  // ==================================================
  // Memory word formats
  // ==================================================
  // H-data word, one per nonzero
  typedef struct packed {
    col_idx_t col_idx;
    data_t    val;
  } h_elem_t;

  // Node-info word, one per H row
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0]  row_len;
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      src_flag;
  } node_info_t;

  // WH word, one per H row
  typedef struct packed {
    wh_sums_t                  sums;
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      src_flag;
  } wh_entry_t;

  // Row and WH address width for a given row count, never below one bit
  function automatic int row_addr_width(int num_rows);
    return (num_rows > 1) ? $clog2(num_rows) : 1;
  endfunction

endpackage

// File: src/spmm_ctrl_pkg.sv
package spmm_ctrl_pkg;

  // ==================================================
  // Controller states
  // ==================================================
  typedef enum logic [2:0] {
    IDLE,
    INFO,
    INFO_WAIT,
    STREAM,
    DRAIN,
    WRITE,
    DONE
  } ctrl_state_e;

  // ==================================================
  // Processing-element opcodes
  // ==================================================
  typedef enum logic [1:0] {
    PE_NOP,
    PE_CLEAR,
    PE_ACC
  } pe_op_e;

endpackage

// File: src/spmm_ctrl.sv
`timescale 1ns/1ps

module spmm_ctrl
  import spmm_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start_i,
  input  logic   row_empty_i,
  input  logic   row_last_elem_i,
  input  logic   run_last_row_i,
  output logic   run_clear_o,
  output logic   len_load_o,
  output logic   elem_step_o,
  output logic   row_step_o,
  output logic   info_capture_o,
  output logic   wh_write_o,
  output pe_op_e pe_op_o,
  output logic   busy_o,
  output logic   done_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // Low in the first drain cycle, high in the second
  logic        drain_q;

  // ==================================================
  // Next state
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = INFO;
        end
      end
      INFO: begin
        state_d = INFO_WAIT;
      end
      INFO_WAIT: begin
        // Empty row skips streaming, sums are already zero
        state_d = row_empty_i ? WRITE : STREAM;
      end
      STREAM: begin
        if (row_last_elem_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (drain_q) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        state_d = run_last_row_i ? DONE : INFO;
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      drain_q <= 1'b0;
    end else begin
      state_q <= state_d;
      drain_q <= (state_q == DRAIN) && !drain_q;
    end
  end

  // ==================================================
  // Strobes to counter, writer and PEs
  // ==================================================
  assign run_clear_o    = (state_q == IDLE) && start_i;
  assign len_load_o     = (state_q == INFO_WAIT);
  assign info_capture_o = (state_q == INFO_WAIT);
  assign elem_step_o    = (state_q == STREAM);
  assign row_step_o     = (state_q == WRITE) && !run_last_row_i;

  // Writer registers the strobe, so it goes out one cycle ahead of WRITE
  assign wh_write_o = (state_d == WRITE);

  // Clear leaves on the cycle entering INFO and reaches the accumulators
  // two stages later, in time for an empty row's WRITE
  always_comb begin
    if (state_d == INFO) begin
      pe_op_o = PE_CLEAR;
    end else if (state_q == STREAM) begin
      pe_op_o = PE_ACC;
    end else begin
      pe_op_o = PE_NOP;
    end
  end

  assign busy_o = (state_q != IDLE);
  assign done_o = (state_q == DONE);

endmodule

// File: src/row_counter.sv
`timescale 1ns/1ps

module row_counter
  import spmm_fmt_pkg::*;
#(
  parameter int  NUM_ROWS   = 12,
  localparam int ROW_ADDR_W = row_addr_width(NUM_ROWS)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      run_clear_i,
  input  logic                      len_load_i,
  input  logic                      elem_step_i,
  input  logic                      row_step_i,
  input  node_info_t                info_i,
  output logic [ROW_ADDR_W-1:0]     info_addr_o,
  output logic [NNZ_ADDR_WIDTH-1:0] h_addr_o,
  output logic                      row_empty_o,
  output logic                      row_last_elem_o,
  output logic                      run_last_row_o
);

  logic [ROW_ADDR_W-1:0]     row_q;
  logic [NNZ_ADDR_WIDTH-1:0] nnz_q;
  logic [ROW_LEN_WIDTH-1:0]  elem_q;

  // ==================================================
  // Counters
  // ==================================================
  // Row index, addresses node info
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_q <= '0;
    end else if (run_clear_i) begin
      row_q <= '0;
    end else if (row_step_i) begin
      row_q <= row_q + 1'b1;
    end
  end

  // Nonzero address, runs on across row boundaries
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nnz_q <= '0;
    end else if (run_clear_i) begin
      nnz_q <= '0;
    end else if (elem_step_i) begin
      nnz_q <= nnz_q + 1'b1;
    end
  end

  // Elements left in the current row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      elem_q <= '0;
    end else if (len_load_i) begin
      elem_q <= info_i.row_len;
    end else if (elem_step_i) begin
      elem_q <= elem_q - 1'b1;
    end
  end

  assign info_addr_o = row_q;
  assign h_addr_o    = nnz_q;

  // ==================================================
  // Row and run flags
  // ==================================================
  // Valid while the node-info word is on the bus
  assign row_empty_o     = (info_i.row_len == '0);
  assign row_last_elem_o = (elem_q == ROW_LEN_WIDTH'(1));
  assign run_last_row_o  = (row_q == ROW_ADDR_W'(NUM_ROWS - 1));

endmodule

// File: src/sp_pe.sv
`timescale 1ns/1ps

module sp_pe
  import spmm_fmt_pkg::*;
  import spmm_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  pe_op_e   op_i,
  input  h_elem_t  elem_i,
  output col_idx_t wgt_addr_o,
  input  data_t    wgt_dout_i,
  output wh_data_t sum_o
);

  // Opcode arrives with the H address, data a cycle later
  pe_op_e                         op_q;
  pe_op_e                         op_s2;
  data_t                          val_s2;
  logic signed [2*DATA_WIDTH-1:0] prod;
  wh_data_t                       acc_q;

  // ==================================================
  // Stage one: weight fetch
  // ==================================================
  assign wgt_addr_o = elem_i.col_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_q  <= PE_NOP;
      op_s2 <= PE_NOP;
    end else begin
      op_q  <= op_i;
      op_s2 <= op_q;
    end
  end

  // ==================================================
  // Stage two: multiply-accumulate
  // ==================================================
  assign prod = val_s2 * wgt_dout_i;

  always_ff @(posedge clk) begin
    val_s2 <= elem_i.val;
    case (op_s2)
      PE_CLEAR: begin
        acc_q <= '0;
      end
      PE_ACC: begin
        // Wraps modulo 2^12
        acc_q <= acc_q + prod[WH_DATA_WIDTH-1:0];
      end
      default: begin
        acc_q <= acc_q;
      end
    endcase
  end

  assign sum_o = acc_q;

endmodule

// File: src/wh_writer.sv
`timescale 1ns/1ps

module wh_writer
  import spmm_fmt_pkg::*;
#(
  parameter int  NUM_ROWS   = 12,
  localparam int ROW_ADDR_W = row_addr_width(NUM_ROWS)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run_clear_i,
  input  logic                  info_capture_i,
  input  logic                  wh_write_i,
  input  node_info_t            info_i,
  input  wh_sums_t              sums_i,
  output wh_entry_t             wh_din_o,
  output logic                  wh_ena_o,
  output logic [ROW_ADDR_W-1:0] wh_addr_o
);

  logic [NUM_NODE_WIDTH-1:0] num_node_q;
  logic                      src_flag_q;
  logic                      ena_q;
  logic [ROW_ADDR_W-1:0]     addr_q;

  // Row metadata, held from INFO_WAIT until the write
  always_ff @(posedge clk) begin
    if (info_capture_i) begin
      num_node_q <= info_i.num_node;
      src_flag_q <= info_i.src_flag;
    end
  end

  // ==================================================
  // Write strobe and address
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ena_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      ena_q <= wh_write_i;
      if (run_clear_i) begin
        addr_q <= '0;
      end else if (ena_q) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // Accumulators settle on the same edge that raises the strobe
  assign wh_din_o = '{sums: sums_i, num_node: num_node_q, src_flag: src_flag_q};

  assign wh_ena_o  = ena_q;
  assign wh_addr_o = addr_q;

endmodule

// File: src/spmm_top.sv
`timescale 1ns/1ps

module spmm_top
  import spmm_fmt_pkg::*;
  import spmm_ctrl_pkg::*;
#(
  parameter int  NUM_ROWS   = 12,
  localparam int ROW_ADDR_W = row_addr_width(NUM_ROWS)
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         start_i,
  output logic                                         busy_o,
  output logic                                         done_o,
  // H-data memory
  output logic [NNZ_ADDR_WIDTH-1:0]                    h_addr_o,
  input  h_elem_t                                      h_dout_i,
  // Node-info memory
  output logic [ROW_ADDR_W-1:0]                        info_addr_o,
  input  node_info_t                                   info_dout_i,
  // Weight memories, one per output feature
  output logic [NUM_FEATURE_OUT-1:0][COL_IDX_WIDTH-1:0] wgt_addr_o,
  input  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0]    wgt_dout_i,
  // WH memory
  output wh_entry_t                                    wh_din_o,
  output logic                                         wh_ena_o,
  output logic [ROW_ADDR_W-1:0]                        wh_addr_o
);

  logic     run_clear;
  logic     len_load;
  logic     elem_step;
  logic     row_step;
  logic     row_empty;
  logic     row_last_elem;
  logic     run_last_row;
  logic     info_capture;
  logic     wh_write;
  pe_op_e   pe_op;
  wh_sums_t sums;

  // ==================================================
  // Control
  // ==================================================
  spmm_ctrl u_spmm_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .row_empty_i     (row_empty),
    .row_last_elem_i (row_last_elem),
    .run_last_row_i  (run_last_row),
    .run_clear_o     (run_clear),
    .len_load_o      (len_load),
    .elem_step_o     (elem_step),
    .row_step_o      (row_step),
    .info_capture_o  (info_capture),
    .wh_write_o      (wh_write),
    .pe_op_o         (pe_op),
    .busy_o          (busy_o),
    .done_o          (done_o)
  );

  row_counter #(
    .NUM_ROWS (NUM_ROWS)
  ) u_row_counter (
    .clk             (clk),
    .rst_n           (rst_n),
    .run_clear_i     (run_clear),
    .len_load_i      (len_load),
    .elem_step_i     (elem_step),
    .row_step_i      (row_step),
    .info_i          (info_dout_i),
    .info_addr_o     (info_addr_o),
    .h_addr_o        (h_addr_o),
    .row_empty_o     (row_empty),
    .row_last_elem_o (row_last_elem),
    .run_last_row_o  (run_last_row)
  );

  // ==================================================
  // Datapath
  // ==================================================
  // PE i computes feature i
  for (genvar i = 0; i < NUM_FEATURE_OUT; i++) begin : g_pe
    sp_pe u_sp_pe (
      .clk        (clk),
      .rst_n      (rst_n),
      .op_i       (pe_op),
      .elem_i     (h_dout_i),
      .wgt_addr_o (wgt_addr_o[i]),
      .wgt_dout_i (wgt_dout_i[i]),
      .sum_o      (sums[i])
    );
  end

  wh_writer #(
    .NUM_ROWS (NUM_ROWS)
  ) u_wh_writer (
    .clk            (clk),
    .rst_n          (rst_n),
    .run_clear_i    (run_clear),
    .info_capture_i (info_capture),
    .wh_write_i     (wh_write),
    .info_i         (info_dout_i),
    .sums_i         (sums),
    .wh_din_o       (wh_din_o),
    .wh_ena_o       (wh_ena_o),
    .wh_addr_o      (wh_addr_o)
  );

endmodule

// File: verif/spmm_tb.sv
`timescale 1ns/1ps

module spmm_tb
  import spmm_fmt_pkg::*;
;

  localparam int          NUM_ROWS    = 12;
  localparam int          ROW_ADDR_W  = row_addr_width(NUM_ROWS);
  localparam int          EMPTY_ROW   = NUM_ROWS / 2;
  localparam int          RUN_TIMEOUT = 2000;
  localparam logic [31:0] LFSR_SEED   = 32'h116c_9f7a;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic                                          clk     = 1'b0;
  logic                                          rst_n   = 1'b0;
  logic                                          start_i = 1'b0;
  logic                                          busy;
  logic                                          done;
  logic [NNZ_ADDR_WIDTH-1:0]                     h_addr;
  h_elem_t                                       h_dout  = '0;
  logic [ROW_ADDR_W-1:0]                         info_addr;
  node_info_t                                    info_dout = '0;
  logic [NUM_FEATURE_OUT-1:0][COL_IDX_WIDTH-1:0] wgt_addr;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0]    wgt_dout = '0;
  wh_entry_t                                     wh_din;
  logic                                          wh_ena;
  logic [ROW_ADDR_W-1:0]                         wh_addr;

  // Memory contents and expected WH sums
  h_elem_t    h_mem     [2**NNZ_ADDR_WIDTH];
  node_info_t info_mem  [2**ROW_ADDR_W];
  data_t      w_mem     [NUM_FEATURE_OUT][NUM_FEATURE_IN];
  wh_data_t   exp_sums  [NUM_ROWS][NUM_FEATURE_OUT];

  logic [31:0] lfsr_state = LFSR_SEED;
  int          error_count = 0;
  int          pass_count  = 0;
  int          fail_count  = 0;

  always #10 clk = ~clk;

  spmm_top #(
    .NUM_ROWS (NUM_ROWS)
  ) u_spmm_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .busy_o      (busy),
    .done_o      (done),
    .h_addr_o    (h_addr),
    .h_dout_i    (h_dout),
    .info_addr_o (info_addr),
    .info_dout_i (info_dout),
    .wgt_addr_o  (wgt_addr),
    .wgt_dout_i  (wgt_dout),
    .wh_din_o    (wh_din),
    .wh_ena_o    (wh_ena),
    .wh_addr_o   (wh_addr)
  );

  // Registered-read memories
  always @(posedge clk) begin
    h_dout    <= h_mem[h_addr];
    info_dout <= info_mem[info_addr];
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      wgt_dout[f] <= w_mem[f][wgt_addr[f]];
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  // Galois LFSR, one step per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic report_error(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Test failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("[%s] ok", name);
    end else begin
      fail_count++;
      $display("[%s] FAIL, %0d errors", name, error_count - errors_before);
    end
  endtask

  // Fills all memories and computes the expected sums
  task automatic fill_memories();
    int       addr;
    int       len;
    int       acc [NUM_FEATURE_OUT];
    col_idx_t col;
    data_t    val;
    for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
      for (int c = 0; c < NUM_FEATURE_IN; c++) begin
        w_mem[f][c] = data_t'(draw_bits(DATA_WIDTH));
      end
    end
    // Unused words get an address pattern
    for (int a = 0; a < 2**NNZ_ADDR_WIDTH; a++) begin
      h_mem[a].col_idx = col_idx_t'(a ^ (a >> 4));
      h_mem[a].val     = data_t'(a ^ 8'ha5);
    end
    for (int a = 0; a < 2**ROW_ADDR_W; a++) begin
      info_mem[a] = node_info_t'(a ^ (a << 5));
    end
    addr = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      len = draw_bits(ROW_LEN_WIDTH) % (NUM_FEATURE_IN + 1);
      if (r == EMPTY_ROW) begin
        len = 0;
      end
      info_mem[r].row_len  = ROW_LEN_WIDTH'(len);
      info_mem[r].num_node = NUM_NODE_WIDTH'(draw_bits(NUM_NODE_WIDTH));
      info_mem[r].src_flag = draw_bits(1) & 1'b1;
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        acc[f] = 0;
      end
      for (int k = 0; k < len; k++) begin
        col = col_idx_t'(draw_bits(COL_IDX_WIDTH));
        val = data_t'(draw_bits(DATA_WIDTH));
        h_mem[addr].col_idx = col;
        h_mem[addr].val     = val;
        addr++;
        for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
          acc[f] += int'(val) * int'(w_mem[f][col]);
        end
      end
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        exp_sums[r][f] = acc[f][WH_DATA_WIDTH-1:0];
      end
    end
  endtask

  // ==================================================
  // Checks
  // ==================================================
  task automatic check_entry(input int idx);
    assert (idx < NUM_ROWS) else begin
      report_error($sformatf("write number %0d beyond the last row", idx));
    end
    if (idx < NUM_ROWS) begin
      assert (wh_addr == ROW_ADDR_W'(idx)) else begin
        report_error($sformatf("wh_addr_o %0d, expected %0d", wh_addr, idx));
      end
      for (int f = 0; f < NUM_FEATURE_OUT; f++) begin
        assert (wh_din.sums[f] == exp_sums[idx][f]) else begin
          report_error($sformatf("row %0d feature %0d sum %0d, expected %0d",
                                 idx, f, $signed(wh_din.sums[f]), exp_sums[idx][f]));
        end
      end
      assert (wh_din.num_node == info_mem[idx].num_node) else begin
        report_error($sformatf("row %0d num_node %0d, expected %0d",
                               idx, wh_din.num_node, info_mem[idx].num_node));
      end
      assert (wh_din.src_flag == info_mem[idx].src_flag) else begin
        report_error($sformatf("row %0d src_flag wrong", idx));
      end
      if (info_mem[idx].row_len == '0) begin
        assert (wh_din.sums == '0) else begin
          report_error($sformatf("empty row %0d has nonzero sums", idx));
        end
      end
    end
  endtask

  task automatic check_reset();
    int errors_before;
    errors_before = error_count;
    repeat (16) begin
      @(negedge clk);
      assert (!busy && !done && !wh_ena) else begin
        report_error("busy_o, done_o or wh_ena_o high in reset");
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      assert (!busy && !done && !wh_ena) else begin
        report_error("busy_o, done_o or wh_ena_o high after reset");
      end
      assert (h_addr == '0 && info_addr == '0 && wh_addr == '0) else begin
        report_error("address not zero after reset");
      end
    end
    report_test("reset", errors_before);
  endtask

  // One run; optional start strobes while busy
  task automatic run_and_check(input string name, input bit poke_busy);
    int errors_before;
    int writes;
    int cyc;
    bit prev_ena;
    bit seen_done;
    errors_before = error_count;
    writes    = 0;
    cyc       = 0;
    prev_ena  = 1'b0;
    seen_done = 1'b0;
    @(posedge clk);
    start_i <= 1'b1;
    while (!seen_done && cyc < RUN_TIMEOUT) begin
      @(posedge clk);
      start_i <= poke_busy && (cyc == 4 || cyc == 30);
      @(negedge clk);
      cyc++;
      assert (busy) else begin
        report_error("busy_o low during a run");
      end
      if (wh_ena) begin
        check_entry(writes);
        writes++;
      end
      if (done) begin
        assert (prev_ena && !wh_ena && writes == NUM_ROWS) else begin
          report_error($sformatf("done_o with %0d writes, previous cycle ena %0b",
                                 writes, prev_ena));
        end
        seen_done = 1'b1;
      end
      prev_ena = wh_ena;
    end
    if (!seen_done) begin
      abort_on_timeout("done_o never pulsed during a run");
    end
    // Idle tail, no stray writes or second done
    repeat (4) begin
      @(negedge clk);
      assert (!busy && !done && !wh_ena) else begin
        report_error("activity after done_o");
      end
    end
    report_test(name, errors_before);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    fill_memories();
    check_reset();
    run_and_check("first run", 1'b0);
    run_and_check("start while busy, second run", 1'b1);
    fill_memories();
    run_and_check("run with new data", 1'b0);
    $display("%0d tests ok, %0d tests failing, %0d check errors",
             pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: project.f
src/spmm_fmt_pkg.sv
src/spmm_ctrl_pkg.sv
src/spmm_ctrl.sv
src/row_counter.sv
src/sp_pe.sv
src/wh_writer.sv
src/spmm_top.sv
verif/spmm_tb.sv
